/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_PC = '0;

    // --------------------------------------------------
    // Opcodes and function codes
    // --------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // --------------------------------------------------
    // Stage payloads
    // --------------------------------------------------
    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t      pc;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      imm;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        alu_op_t    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        logic       writes_rd;
        logic       is_branch;
        logic [2:0] funct3;
        logic       is_jal;
    } id_ex_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      writes_rd;
        word_t     result;
        word_t     pc;
    } ex_wb_t;

endpackage

`default_nettype wire

/* hdl/pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// One pipeline register. Only the valid bit is control state.
module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic flush,
    input  wire logic in_valid,
    input  payload_t  in_payload,
    output logic      out_valid,
    output payload_t  out_payload
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        out_payload <= in_payload;
    end

endmodule

`default_nettype wire

/* hdl/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic redirect,
    input  word_t     redirect_pc,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output logic      fd_valid,
    output if_id_t    fd_payload
);

    word_t  pc;
    word_t  pc_next;
    if_id_t fetched;

    assign pc_next = redirect ? redirect_pc : pc + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;
    assign fetched   = '{pc: pc, instr: imem_data};

    // The word fetched during a redirect is on the wrong path.
    pipe_stage #(.payload_t(if_id_t)) i_fd_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (redirect),
        .in_valid   (1'b1),
        .in_payload (fetched),
        .out_valid  (fd_valid),
        .out_payload(fd_payload)
    );

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic redirect,
    input  wire logic fd_valid,
    input  if_id_t    fd_payload,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output logic      de_valid,
    output id_ex_t    de_payload
);

    function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt_add,
                                            input logic alt_sr);
        alu_op_t op;
        case (f3)
            F3_ADD:  op = alt_add ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt_sr ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    word_t      instr;
    logic [6:0] opcode;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_b;
    word_t      imm_j;
    id_ex_t     dec;

    assign instr    = fd_payload.instr;
    assign opcode   = instr[6:0];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec         = '0;
        dec.pc      = fd_payload.pc;
        dec.rs1_val = rs1_data;
        dec.rs2_val = rs2_data;
        dec.rs1     = rs1_addr;
        dec.rs2     = rs2_addr;
        dec.rd      = instr[11:7];
        dec.funct3  = instr[14:12];
        dec.imm     = imm_i;
        dec.alu_op  = ALU_ADD;
        // Unknown opcodes keep every flag clear and fall through as bubbles.
        case (opcode)
            OPC_OP: begin
                dec.alu_op    = alu_from_f3(instr[14:12], instr[30], instr[30]);
                dec.writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.alu_op    = alu_from_f3(instr[14:12], 1'b0, instr[30]);
                dec.b_is_imm  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_LUI: begin
                dec.imm       = imm_u;
                dec.alu_op    = ALU_PASS_B;
                dec.b_is_imm  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                dec.imm       = imm_u;
                dec.a_is_pc   = 1'b1;
                dec.b_is_imm  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
            end
            default: ;
        endcase
    end

    pipe_stage #(.payload_t(id_ex_t)) i_de_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (redirect),
        .in_valid   (fd_valid),
        .in_payload (dec),
        .out_valid  (de_valid),
        .out_payload(de_payload)
    );

endmodule

`default_nettype wire

/* hdl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic de_valid,
    input  id_ex_t    de_payload,
    input  wire logic wb_valid_write,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output logic      redirect,
    output word_t     redirect_pc,
    output logic      ex_valid,
    output ex_wb_t    ex_payload
);

    word_t  rs1_v;
    word_t  rs2_v;
    word_t  op_a;
    word_t  op_b;
    word_t  alu_res;
    logic   taken;
    ex_wb_t result;

    // --------------------------------------------------
    // Forwarding from write-back
    // --------------------------------------------------
    assign rs1_v = (wb_valid_write && wb_rd == de_payload.rs1 && de_payload.rs1 != '0) ?
                   wb_data : de_payload.rs1_val;
    assign rs2_v = (wb_valid_write && wb_rd == de_payload.rs2 && de_payload.rs2 != '0) ?
                   wb_data : de_payload.rs2_val;

    assign op_a = de_payload.a_is_pc  ? de_payload.pc  : rs1_v;
    assign op_b = de_payload.b_is_imm ? de_payload.imm : rs2_v;

    always_comb begin
        case (de_payload.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // --------------------------------------------------
    // Branch decision
    // --------------------------------------------------
    always_comb begin
        case (de_payload.funct3)
            F3_BEQ:  taken = rs1_v == rs2_v;
            F3_BNE:  taken = rs1_v != rs2_v;
            F3_BLT:  taken = $signed(rs1_v) < $signed(rs2_v);
            F3_BGE:  taken = $signed(rs1_v) >= $signed(rs2_v);
            F3_BLTU: taken = rs1_v < rs2_v;
            F3_BGEU: taken = rs1_v >= rs2_v;
            default: taken = 1'b0;
        endcase
    end

    // Branches and JAL share the pc-relative target.
    assign redirect    = de_valid & ((de_payload.is_branch & taken) | de_payload.is_jal);
    assign redirect_pc = de_payload.pc + de_payload.imm;

    assign result.rd        = de_payload.rd;
    assign result.writes_rd = de_payload.writes_rd;
    assign result.result    = de_payload.is_jal ? de_payload.pc + 32'd4 : alu_res;
    assign result.pc        = de_payload.pc;

    pipe_stage #(.payload_t(ex_wb_t)) i_ex_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (1'b0),
        .in_valid   (de_valid),
        .in_payload (result),
        .out_valid  (ex_valid),
        .out_payload(ex_payload)
    );

endmodule

`default_nettype wire

/* hdl/rv_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_writeback import rv_pkg::*; (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic ex_valid,
    input  ex_wb_t    ex_payload,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output logic      wb_valid_write,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output word_t     retire_data,
    output word_t     retire_pc
);

    // x0 has no storage.
    word_t regs [1:31];

    assign wb_valid_write = ex_valid & ex_payload.writes_rd & (ex_payload.rd != '0);
    assign wb_rd          = ex_payload.rd;
    assign wb_data        = ex_payload.result;

    assign retire_valid = wb_valid_write;
    assign retire_rd    = ex_payload.rd;
    assign retire_data  = ex_payload.result;
    assign retire_pc    = ex_payload.pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid_write) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // A read of the register being written sees the new value.
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (wb_valid_write && rs1_addr == wb_rd) begin
            rs1_data = wb_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (wb_valid_write && rs2_addr == wb_rd) begin
            rs2_data = wb_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
    input  wire logic clk,
    input  wire logic arst_n,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output logic      retire_valid,
    output reg_addr_t retire_rd,
    output word_t     retire_data,
    output word_t     retire_pc
);

    logic      redirect;
    word_t     redirect_pc;
    logic      fd_valid;
    if_id_t    fd_payload;
    logic      de_valid;
    id_ex_t    de_payload;
    logic      ex_valid;
    ex_wb_t    ex_payload;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wb_valid_write;
    reg_addr_t wb_rd;
    word_t     wb_data;

    rv_fetch i_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .fd_valid   (fd_valid),
        .fd_payload (fd_payload)
    );

    rv_decode i_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .redirect  (redirect),
        .fd_valid  (fd_valid),
        .fd_payload(fd_payload),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .de_valid  (de_valid),
        .de_payload(de_payload)
    );

    rv_execute i_execute (
        .clk           (clk),
        .arst_n        (arst_n),
        .de_valid      (de_valid),
        .de_payload    (de_payload),
        .wb_valid_write(wb_valid_write),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .ex_valid      (ex_valid),
        .ex_payload    (ex_payload)
    );

    rv_writeback i_writeback (
        .clk           (clk),
        .arst_n        (arst_n),
        .ex_valid      (ex_valid),
        .ex_payload    (ex_payload),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wb_valid_write(wb_valid_write),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data),
        .retire_pc     (retire_pc)
    );

endmodule

`default_nettype wire

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Each expected retire holds the destination register, the written value and the pc.
typedef struct packed {
    reg_addr_t rd;
    word_t     data;
    word_t     pc;
} retire_exp_t;

localparam word_t JAL_SELF = 32'h0000_006F;

// Word n sits at byte address 4*n. The tail spins on jal x0, 0.
localparam word_t PROGRAM [32] = '{
    32'h0050_0093,  // 0x00 addi x1, x0, 5
    32'hFFD0_0113,  // 0x04 addi x2, x0, -3
    32'h0F00_C193,  // 0x08 xori x3, x1, 0xf0
    32'h0011_2213,  // 0x0c slti x4, x2, 1
    32'h4011_5293,  // 0x10 srai x5, x2, 1
    32'h1234_5337,  // 0x14 lui x6, 0x12345
    32'h0000_1397,  // 0x18 auipc x7, 0x1
    32'h0063_8433,  // 0x1c add x8, x7, x6
    32'h4014_04B3,  // 0x20 sub x9, x8, x1
    32'h0044_9533,  // 0x24 sll x10, x9, x4
    32'h0024_B5B3,  // 0x28 sltu x11, x9, x2
    32'h00B5_6633,  // 0x2c or x12, x10, x11
    32'h0036_76B3,  // 0x30 and x13, x12, x3
    32'h00D6_8663,  // 0x34 beq x13, x13, +12
    32'h0010_0713,  // 0x38 addi x14, x0, 1
    32'h0020_0793,  // 0x3c addi x15, x0, 2
    32'h0070_0813,  // 0x40 addi x16, x0, 7
    32'h0101_4663,  // 0x44 blt x2, x16, +12
    32'h0030_0713,  // 0x48 addi x14, x0, 3
    32'h0040_0793,  // 0x4c addi x15, x0, 4
    32'h0010_9463,  // 0x50 bne x1, x1, +8
    32'h0018_0893,  // 0x54 addi x17, x16, 1
    32'h0020_F463,  // 0x58 bgeu x1, x2, +8
    32'h0028_8913,  // 0x5c addi x18, x17, 2
    32'h00C0_09EF,  // 0x60 jal x19, +12
    32'h0050_0713,  // 0x64 addi x14, x0, 5
    32'h0060_0793,  // 0x68 addi x15, x0, 6
    32'h0090_0013,  // 0x6c addi x0, x0, 9
    32'h0130_0A33,  // 0x70 add x20, x0, x19
    32'h0010_6AB3,  // 0x74 or x21, x0, x1
    32'h0000_006F,  // 0x78 jal x0, 0
    32'h0000_006F
};

localparam int EXP_COUNT = 19;

// Columns are rd, data, pc. Squashed and x0 writers have no row.
localparam retire_exp_t EXPECTED [EXP_COUNT] = '{
    '{5'd1,  32'h0000_0005, 32'h0000_0000},
    '{5'd2,  32'hFFFF_FFFD, 32'h0000_0004},
    '{5'd3,  32'h0000_00F5, 32'h0000_0008},
    '{5'd4,  32'h0000_0001, 32'h0000_000C},
    '{5'd5,  32'hFFFF_FFFE, 32'h0000_0010},
    '{5'd6,  32'h1234_5000, 32'h0000_0014},
    '{5'd7,  32'h0000_1018, 32'h0000_0018},
    '{5'd8,  32'h1234_6018, 32'h0000_001C},
    '{5'd9,  32'h1234_6013, 32'h0000_0020},
    '{5'd10, 32'h2468_C026, 32'h0000_0024},
    '{5'd11, 32'h0000_0001, 32'h0000_0028},
    '{5'd12, 32'h2468_C027, 32'h0000_002C},
    '{5'd13, 32'h0000_0025, 32'h0000_0030},
    '{5'd16, 32'h0000_0007, 32'h0000_0040},
    '{5'd17, 32'h0000_0008, 32'h0000_0054},
    '{5'd18, 32'h0000_000A, 32'h0000_005C},
    '{5'd19, 32'h0000_0064, 32'h0000_0060},
    '{5'd20, 32'h0000_0064, 32'h0000_0070},
    '{5'd21, 32'h0000_0005, 32'h0000_0074}
};

`endif

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    logic      clk;
    logic      arst_n;
    word_t     imem_addr;
    word_t     imem_data;
    logic      retire_valid;
    reg_addr_t retire_rd;
    word_t     retire_data;
    word_t     retire_pc;

    int errors;
    int passes;

    `include "tb_program.svh"

    rv_core i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .retire_valid(retire_valid),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .retire_pc   (retire_pc)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // The instruction ROM answers in the same cycle as the address.
    always_comb begin
        if (imem_addr[31:7] == '0) begin
            imem_data = PROGRAM[imem_addr[6:2]];
        end else begin
            imem_data = JAL_SELF;
        end
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    initial begin
        int   cycles;
        int   errors_before;
        int   extra;
        logic found;

        errors = 0;
        passes = 0;
        arst_n = 1'b0;

        errors_before = errors;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (retire_valid !== 1'b0) begin
                $display("Retire strobe seen while reset is asserted.");
                errors++;
            end
        end
        check_word("imem_addr", imem_addr, RESET_PC);
        $display("reset: %s", (errors == errors_before) ? "ok" : "mismatch");
        if (errors == errors_before) begin
            passes++;
        end
        arst_n = 1'b1;

        for (int n = 0; n < EXP_COUNT; n++) begin
            errors_before = errors;
            found = 1'b0;
            cycles = 0;
            while (!found && cycles < 50) begin
                @(negedge clk);
                cycles++;
                found = (retire_valid === 1'b1);
            end
            if (!found) begin
                $display("Retire %0d for x%0d did not arrive within 50 cycles.",
                         n, EXPECTED[n].rd);
                errors++;
            end else begin
                check_reg("retire_rd", retire_rd, EXPECTED[n].rd);
                check_word("retire_data", retire_data, EXPECTED[n].data);
                check_word("retire_pc", retire_pc, EXPECTED[n].pc);
            end
            $display("retire %0d at pc 0x%h: %s", n, EXPECTED[n].pc,
                     (errors == errors_before) ? "ok" : "mismatch");
            if (errors == errors_before) begin
                passes++;
            end
        end

        // The program now spins on its self-loop and must stay silent.
        extra = 0;
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            if (retire_valid !== 1'b0) begin
                extra++;
            end
        end
        if (extra != 0) begin
            $display("Saw %0d retire strobes after the last expected one.", extra);
            errors++;
        end else begin
            passes++;
        end
        $display("quiet period: %s", (extra == 0) ? "ok" : "mismatch");

        $display("Tests passed: %0d, errors: %0d", passes, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+testbench
hdl/rv_pkg.sv
hdl/pipe_stage.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_writeback.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_rv_core -o tb_rv_core
./obj_dir/tb_rv_core | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure."
    exit 1
fi
echo "Simulation finished without failures."
